// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_accel_top
LOG       ?= sim.log
FLAGS     ?= --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f filelist.f

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -F -q '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
hdl/accel_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/packet_rx.sv
hdl/csr_regs.sv
hdl/operand_buffer.sv
hdl/mac_engine.sv
hdl/response_tx.sv
hdl/accel_top.sv
verif/tb_accel_top.sv

// File: hdl/accel_pkg.sv
// ====================
// Shared sizes, command codes, CSR map and packet types
// Every accelerator module imports this package
// ====================
package accel_pkg;

    // ====================
    // Serial timing and sizes
    localparam int CLKS_PER_BIT = 16;
    localparam int PKT_BYTES    = 7;
    localparam int LANES        = 4;
    localparam int BUF_DEPTH    = 16;
    localparam int BUF_AW       = 4;
    localparam int KLEN_W       = 5;
    localparam int ACC_W        = 32;

    // Command codes, upper nibble of the command byte
    localparam logic [3:0] CMD_CSR_WR     = 4'h0;
    localparam logic [3:0] CMD_CSR_RD     = 4'h1;
    localparam logic [3:0] CMD_BUF_WR_A   = 4'h2;
    localparam logic [3:0] CMD_BUF_WR_B   = 4'h3;
    localparam logic [3:0] CMD_BUF_RD_OUT = 4'h4;
    localparam logic [3:0] CMD_START      = 4'h5;
    localparam logic [3:0] CMD_STATUS     = 4'h7;

    // CSR map
    localparam logic [7:0] CSR_KLEN    = 8'h00;
    localparam logic [7:0] CSR_SCRATCH = 8'h04;

    // ====================
    // Packet types
    typedef logic [7:0] byte_t;

    // Lane 0 sits in the low byte
    typedef logic [LANES-1:0][7:0] lanes_t;

    typedef union packed {
        logic [31:0] word;
        lanes_t      lanes;
    } pkt_data_u;

    typedef struct packed {
        byte_t       cmd;
        logic [15:0] addr;
        pkt_data_u   data;
        byte_t       pad;
    } pkt_t;

    typedef struct packed {
        byte_t       hdr;
        logic [31:0] data;
    } resp_t;

endpackage

// File: hdl/accel_top.sv
// ====================
// Accelerator top level, serial command decode and block wiring
// ====================
`timescale 1ns/1ps

module accel_top import accel_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic i_uart_rx,
    output logic o_uart_tx,
    output logic o_busy,
    output logic o_done,
    output logic o_error
);

    typedef enum logic [1:0] {SEL_CSR, SEL_RESULT, SEL_STATUS} resp_sel_e;

    byte_t             rx_byte;
    logic              rx_valid;
    logic              frm_err;
    pkt_t              pkt;
    logic              pkt_valid;
    logic [3:0]        cmd_code;
    logic              csr_wen;
    logic              wr_a;
    logic              wr_b;
    logic              start;
    logic              resp_req;
    resp_sel_e         resp_sel;
    logic [31:0]       csr_rdata;
    logic [KLEN_W-1:0] klen;
    logic [BUF_AW-1:0] raddr;
    lanes_t            act;
    lanes_t            wgt;
    logic [ACC_W-1:0]  result;
    resp_t             resp;
    byte_t             tx_data;
    logic              tx_valid;
    logic              tx_ready;

    assign cmd_code = pkt.cmd[7:4];

    // ====================
    // Command decode
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_wen  <= 1'b0;
            wr_a     <= 1'b0;
            wr_b     <= 1'b0;
            start    <= 1'b0;
            resp_req <= 1'b0;
            resp_sel <= SEL_CSR;
            o_error  <= 1'b0;
        end else begin
            csr_wen  <= pkt_valid && (cmd_code == CMD_CSR_WR);
            wr_a     <= pkt_valid && (cmd_code == CMD_BUF_WR_A);
            wr_b     <= pkt_valid && (cmd_code == CMD_BUF_WR_B);
            start    <= pkt_valid && (cmd_code == CMD_START);
            resp_req <= pkt_valid && (cmd_code == CMD_CSR_RD ||
                                      cmd_code == CMD_BUF_RD_OUT ||
                                      cmd_code == CMD_STATUS);
            if (pkt_valid) begin
                case (cmd_code)
                    CMD_BUF_RD_OUT: resp_sel <= SEL_RESULT;
                    CMD_STATUS:     resp_sel <= SEL_STATUS;
                    default:        resp_sel <= SEL_CSR;
                endcase
            end
            // Sticky until reset
            if (frm_err) begin
                o_error <= 1'b1;
            end
        end
    end

    // Packet fields stay stable until the next command byte arrives
    always_comb begin
        resp.hdr = pkt.cmd;
        case (resp_sel)
            SEL_RESULT: resp.data = result;
            SEL_STATUS: resp.data = {30'd0, o_error, o_busy};
            default:    resp.data = csr_rdata;
        endcase
    end

    // ====================
    // Blocks
    uart_rx u_uart_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rx      (i_uart_rx),
        .o_data    (rx_byte),
        .o_valid   (rx_valid),
        .o_frm_err (frm_err)
    );

    packet_rx u_packet_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_byte       (rx_byte),
        .i_byte_valid (rx_valid),
        .o_pkt        (pkt),
        .o_pkt_valid  (pkt_valid)
    );

    csr_regs u_csr_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wen   (csr_wen),
        .i_addr  (pkt.addr[7:0]),
        .i_wdata (pkt.data),
        .o_rdata (csr_rdata),
        .o_klen  (klen)
    );

    operand_buffer u_act_buf (
        .clk     (clk),
        .i_we    (wr_a),
        .i_waddr (pkt.addr[BUF_AW-1:0]),
        .i_wdata (pkt.data.lanes),
        .i_raddr (raddr),
        .o_rdata (act)
    );

    operand_buffer u_wgt_buf (
        .clk     (clk),
        .i_we    (wr_b),
        .i_waddr (pkt.addr[BUF_AW-1:0]),
        .i_wdata (pkt.data.lanes),
        .i_raddr (raddr),
        .o_rdata (wgt)
    );

    mac_engine u_mac_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_start  (start),
        .i_klen   (klen),
        .o_raddr  (raddr),
        .i_act    (act),
        .i_wgt    (wgt),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_result (result)
    );

    response_tx u_response_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (resp_req),
        .i_resp     (resp),
        .i_tx_ready (tx_ready),
        .o_tx_data  (tx_data),
        .o_tx_valid (tx_valid)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_data  (tx_data),
        .i_valid (tx_valid),
        .o_ready (tx_ready),
        .o_tx    (o_uart_tx)
    );

endmodule

// File: hdl/csr_regs.sv
// ====================
// Job length and scratch registers
// Written from CSR write packets, read back combinationally
// ====================
`timescale 1ns/1ps

module csr_regs import accel_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_wen,
    input  byte_t             i_addr,
    input  pkt_data_u         i_wdata,
    output logic [31:0]       o_rdata,
    output logic [KLEN_W-1:0] o_klen
);

    logic [KLEN_W-1:0] klen_q;
    logic [31:0]       scratch_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            klen_q    <= '0;
            scratch_q <= '0;
        end else if (i_wen) begin
            case (i_addr)
                // Upper bits of the length are dropped
                CSR_KLEN:    klen_q    <= i_wdata.word[KLEN_W-1:0];
                CSR_SCRATCH: scratch_q <= i_wdata.word;
                default:     ;
            endcase
        end
    end

    always_comb begin
        case (i_addr)
            CSR_KLEN:    o_rdata = 32'(klen_q);
            CSR_SCRATCH: o_rdata = scratch_q;
            default:     o_rdata = '0;
        endcase
    end

    assign o_klen = klen_q;

endmodule

// File: hdl/mac_engine.sv
// ====================
// Dot-product engine over the two operand buffers
// Start while idle, o_done pulses with the final result in o_result
// ====================
`timescale 1ns/1ps

module mac_engine import accel_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_start,
    input  logic [KLEN_W-1:0] i_klen,
    output logic [BUF_AW-1:0] o_raddr,
    input  lanes_t            i_act,
    input  lanes_t            i_wgt,
    output logic              o_busy,
    output logic              o_done,
    output logic [ACC_W-1:0]  o_result
);

    logic [KLEN_W-1:0]       issue_cnt;
    logic                    issuing;
    logic                    rd_valid;
    logic signed [ACC_W-1:0] dot;

    assign issuing = o_busy && (issue_cnt < i_klen);
    assign o_raddr = issue_cnt[BUF_AW-1:0];

    // Signed products of all lanes, summed
    always_comb begin
        dot = '0;
        for (int l = 0; l < LANES; l++) begin
            dot = dot + ACC_W'($signed(i_act[l]) * $signed(i_wgt[l]));
        end
    end

    // Read of word k+1 overlaps the add of word k, so the job ends
    // in the first busy cycle with nothing left to issue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_busy    <= 1'b0;
            o_done    <= 1'b0;
            rd_valid  <= 1'b0;
            issue_cnt <= '0;
            o_result  <= '0;
        end else begin
            o_done   <= 1'b0;
            rd_valid <= issuing;
            if (rd_valid) begin
                o_result <= o_result + dot;
            end
            if (i_start && !o_busy) begin
                o_busy    <= 1'b1;
                issue_cnt <= '0;
                o_result  <= '0;
            end else if (issuing) begin
                issue_cnt <= issue_cnt + 1'b1;
            end else if (o_busy) begin
                o_busy <= 1'b0;
                o_done <= 1'b1;
            end
        end
    end

    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        o_done |-> $past(o_busy));

endmodule

// File: hdl/operand_buffer.sv
// ====================
// Operand word memory, four int8 lanes per word
// One write port, one read port with a registered output
// ====================
`timescale 1ns/1ps

module operand_buffer import accel_pkg::*; (
    input  logic              clk,
    input  logic              i_we,
    input  logic [BUF_AW-1:0] i_waddr,
    input  lanes_t            i_wdata,
    input  logic [BUF_AW-1:0] i_raddr,
    output lanes_t            o_rdata
);

    lanes_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        // Read data shows up one cycle after the address
        o_rdata <= mem[i_raddr];
    end

endmodule

// File: hdl/packet_rx.sv
// ====================
// Builds a seven-byte command packet from received bytes
// o_pkt_valid pulses once the last byte is placed
// ====================
`timescale 1ns/1ps

module packet_rx import accel_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t i_byte,
    input  logic  i_byte_valid,
    output pkt_t  o_pkt,
    output logic  o_pkt_valid
);

    logic [2:0] idx;

    // Byte index and completion pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx         <= '0;
            o_pkt_valid <= 1'b0;
        end else begin
            o_pkt_valid <= 1'b0;
            if (i_byte_valid) begin
                if (int'(idx) == PKT_BYTES - 1) begin
                    idx         <= '0;
                    o_pkt_valid <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Order is cmd, addr lo, addr hi, then data LSB first
    always_ff @(posedge clk) begin
        o_pkt.pad <= '0;
        if (i_byte_valid) begin
            case (idx)
                3'd0:    o_pkt.cmd        <= i_byte;
                3'd1:    o_pkt.addr[7:0]  <= i_byte;
                3'd2:    o_pkt.addr[15:8] <= i_byte;
                default: o_pkt.data.word[8 * (int'(idx) - 3) +: 8] <= i_byte;
            endcase
        end
    end

    idx_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(idx) <= PKT_BYTES - 1);

endmodule

// File: hdl/response_tx.sv
// ====================
// Sends a response as header byte plus four data bytes
// Data goes LSB first, each byte only while the transmitter is ready
// ====================
`timescale 1ns/1ps

module response_tx import accel_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_req,
    input  resp_t i_resp,
    input  logic  i_tx_ready,
    output byte_t o_tx_data,
    output logic  o_tx_valid
);

    typedef enum logic [1:0] {TX_IDLE, TX_HDR, TX_DATA} tx_state_e;

    tx_state_e  state;
    logic [1:0] byte_cnt;
    resp_t      resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: if (i_req) state <= TX_HDR;
                TX_HDR: begin
                    if (i_tx_ready) begin
                        state    <= TX_DATA;
                        byte_cnt <= '0;
                    end
                end
                default: begin
                    if (i_tx_ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            state <= TX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_req && state == TX_IDLE) begin
            resp_q <= i_resp;
        end
    end

    assign o_tx_valid = (state != TX_IDLE);
    assign o_tx_data  = (state == TX_HDR) ? resp_q.hdr : resp_q.data[{byte_cnt, 3'b000} +: 8];

    // A packet takes longer than a response, so they never overlap
    no_req_while_active: assert property (@(posedge clk) disable iff (!rst_n)
        i_req |-> state == TX_IDLE);

endmodule

// File: hdl/uart_rx.sv
// ====================
// 8N1 serial receiver, samples each bit at its middle
// Pulses o_valid per good byte, o_frm_err on a low stop bit
// ====================
`timescale 1ns/1ps

module uart_rx import accel_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_rx,
    output byte_t o_data,
    output logic  o_valid,
    output logic  o_frm_err
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                         state;
    logic [2:0]                        rx_sync;
    logic [$clog2(CLKS_PER_BIT)-1:0]   cnt;
    logic [2:0]                        bit_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            rx_sync   <= '1;
            cnt       <= '0;
            bit_idx   <= '0;
            o_valid   <= 1'b0;
            o_frm_err <= 1'b0;
        end else begin
            o_valid   <= 1'b0;
            o_frm_err <= 1'b0;
            // Two sync flops, third one keeps the last value for edge detect
            rx_sync   <= {rx_sync[1:0], i_rx};
            cnt       <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (rx_sync[2] && !rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (int'(cnt) == CLKS_PER_BIT / 2 - 1) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // Glitch shorter than half a bit is dropped
                        state   <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (int'(cnt) == CLKS_PER_BIT - 1) begin
                        cnt     <= '0;
                        o_data  <= {rx_sync[1], o_data[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (int'(cnt) == CLKS_PER_BIT - 1) begin
                        state     <= RX_IDLE;
                        o_valid   <= rx_sync[1];
                        o_frm_err <= !rx_sync[1];
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/uart_tx.sv
// ====================
// 8N1 serial transmitter
// Takes a byte on i_valid while o_ready is high
// ====================
`timescale 1ns/1ps

module uart_tx import accel_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t i_data,
    input  logic  i_valid,
    output logic  o_ready,
    output logic  o_tx
);

    logic                              busy;
    logic [8:0]                        shreg;
    logic [$clog2(CLKS_PER_BIT)-1:0]   cnt;
    logic [3:0]                        bit_idx;

    assign o_ready = !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            o_tx    <= 1'b1;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (i_valid) begin
                // Start bit goes out now, stop bit waits above the data
                busy    <= 1'b1;
                shreg   <= {1'b1, i_data};
                o_tx    <= 1'b0;
                cnt     <= '0;
                bit_idx <= '0;
            end
        end else if (int'(cnt) == CLKS_PER_BIT - 1) begin
            cnt <= '0;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end else begin
                o_tx    <= shreg[0];
                shreg   <= {1'b1, shreg[8:1]};
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: verif/tb_accel_top.sv
// ====================
// Directed testbench that drives the accelerator over its serial port
// Responses are collected by a serial monitor into a byte queue
// ====================
`timescale 1ns/1ps

module tb_accel_top import accel_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int BYTE_CYCLES = 10 * CLKS_PER_BIT;
    localparam int NUM_PACKETS = 47;
    localparam int WATCHDOG_NS = NUM_PACKETS * 12 * BYTE_CYCLES * CLK_PERIOD * 2;
    localparam int RESP_CYCLES = 8 * BYTE_CYCLES;
    localparam int JOB_CYCLES  = 2 * PKT_BYTES * BYTE_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        i_uart_rx;
    logic        o_uart_tx;
    logic        o_busy;
    logic        o_done;
    logic        o_error;
    integer      seed;
    byte_t       rx_q[$];
    logic [31:0] act_w[BUF_DEPTH];
    logic [31:0] wgt_w[BUF_DEPTH];
    logic [31:0] scratch_val;

    accel_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_busy    (o_busy),
        .o_done    (o_done),
        .o_error   (o_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at time %0t: %s, got 0x%08h, expected 0x%08h",
                                $time, msg, got, exp));
        end
    endtask

    // ====================
    // Serial port model
    task automatic drive_bit(input logic v);
        i_uart_rx = v;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input byte_t b, input bit bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(!bad_stop);
    endtask

    task automatic send_packet(input byte_t cmd, input logic [15:0] addr,
                               input logic [31:0] data);
        send_byte(cmd, 1'b0);
        send_byte(addr[7:0], 1'b0);
        send_byte(addr[15:8], 1'b0);
        for (int i = 0; i < 4; i++) begin
            send_byte(data[8*i +: 8], 1'b0);
        end
    endtask

    // Runs from the first low sample of a start bit and reads each bit at its middle
    task automatic recv_byte(output byte_t b);
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        if (o_uart_tx !== 1'b0) begin
            abort_run("Start bit on the response line was too short");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = o_uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (o_uart_tx !== 1'b1) begin
            abort_run("Stop bit of a response byte was low");
        end
    endtask

    initial begin : serial_monitor
        byte_t b;
        forever begin
            @(negedge clk);
            if (o_uart_tx === 1'b0) begin
                recv_byte(b);
                rx_q.push_back(b);
            end
        end
    end

    task automatic recv_response(output byte_t hdr, output logic [31:0] data);
        int waited;
        waited = 0;
        while (rx_q.size() < 5) begin
            @(negedge clk);
            waited++;
            if (waited > RESP_CYCLES) begin
                abort_run("No complete response arrived on the serial line");
            end
        end
        hdr = rx_q.pop_front();
        for (int i = 0; i < 4; i++) begin
            data[8*i +: 8] = rx_q.pop_front();
        end
    endtask

    // Sends a read-type packet and checks header and data
    task automatic query(input byte_t cmd, input logic [15:0] addr,
                         input logic [31:0] exp, input string what);
        byte_t       hdr;
        logic [31:0] data;
        send_packet(cmd, addr, 32'h0);
        recv_response(hdr, data);
        check(32'(hdr), 32'(cmd), {what, " header"});
        check(data, exp, what);
    endtask

    task automatic wait_job(input bit need_busy);
        int cycles;
        bit seen_busy;
        cycles    = 0;
        seen_busy = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            if (o_busy === 1'b1) begin
                seen_busy = 1'b1;
            end
            if (cycles > JOB_CYCLES) begin
                abort_run("The MAC engine never pulsed done");
            end
        end while (o_done !== 1'b1);
        if (need_busy) begin
            check(32'(seen_busy), 32'd1, "busy seen before done");
        end
    endtask

    function automatic logic [31:0] expected_dot(input int klen);
        int  sum;
        byte sa;
        byte sb;
        sum = 0;
        for (int k = 0; k < klen; k++) begin
            for (int l = 0; l < LANES; l++) begin
                sa  = act_w[k][8*l +: 8];
                sb  = wgt_w[k][8*l +: 8];
                sum = sum + int'(sa) * int'(sb);
            end
        end
        return sum;
    endfunction

    // ====================
    // Directed tests
    task automatic test_status_after_reset();
        check(32'(o_busy), 32'd0, "busy after reset");
        check(32'(o_error), 32'd0, "error after reset");
        query({CMD_STATUS, 4'h0}, 16'h0, 32'h0, "status after reset");
    endtask

    task automatic test_csr_access();
        scratch_val = $random(seed);
        send_packet({CMD_CSR_WR, 4'h0}, 16'(CSR_SCRATCH), scratch_val);
        query({CMD_CSR_RD, 4'hA}, 16'(CSR_SCRATCH), scratch_val, "scratch readback");
        send_packet({CMD_CSR_WR, 4'h0}, 16'(CSR_KLEN), 32'hFFFF_FFFF);
        query({CMD_CSR_RD, 4'h3}, 16'(CSR_KLEN), 32'h1F, "klen readback");
    endtask

    task automatic test_dot_product();
        int klen;
        for (int k = 0; k < BUF_DEPTH; k++) begin
            act_w[k] = $random(seed);
            wgt_w[k] = $random(seed);
            send_packet({CMD_BUF_WR_A, 4'h0}, 16'(k), act_w[k]);
            send_packet({CMD_BUF_WR_B, 4'h0}, 16'(k), wgt_w[k]);
        end
        klen = int'($unsigned($random(seed)) % 16) + 1;
        send_packet({CMD_CSR_WR, 4'h0}, 16'(CSR_KLEN), 32'(klen));
        // Busy rises while the stop bit of the start packet is still on the line
        fork
            send_packet({CMD_START, 4'h0}, 16'h0, 32'h0);
            wait_job(1'b1);
        join
        check(32'(o_busy), 32'd0, "busy after done");
        query({CMD_BUF_RD_OUT, 4'h0}, 16'h0, expected_dot(klen), "dot product result");
    endtask

    task automatic test_zero_length();
        send_packet({CMD_CSR_WR, 4'h0}, 16'(CSR_KLEN), 32'h0);
        fork
            send_packet({CMD_START, 4'h0}, 16'h0, 32'h0);
            wait_job(1'b0);
        join
        query({CMD_BUF_RD_OUT, 4'h0}, 16'h0, 32'h0, "zero length result");
    endtask

    task automatic test_error_and_unknown();
        send_byte(8'h5A, 1'b1);
        drive_bit(1'b1);
        check(32'(o_error), 32'd1, "error after bad stop bit");
        query({CMD_STATUS, 4'h0}, 16'h0, 32'h2, "status after framing error");
        send_packet(8'h90, 16'(CSR_SCRATCH), ~scratch_val);
        repeat (20 * BYTE_CYCLES) @(negedge clk);
        check(32'(rx_q.size()), 32'd0, "bytes sent for unknown command");
        query({CMD_CSR_RD, 4'h0}, 16'(CSR_SCRATCH), scratch_val, "scratch after unknown");
        check(32'(o_error), 32'd1, "error stays set");
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Timeout, the tests did not finish in time");
    end

    initial begin
        seed      = 32'hba53b1e9;
        rst_n     = 1'b0;
        i_uart_rx = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        test_status_after_reset();
        test_csr_access();
        test_dot_product();
        test_zero_length();
        test_error_and_unknown();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
